//--- all.f
+incdir+tb
rtl/noc_cfg_pkg.sv
rtl/flit_pkg.sv
rtl/vc_fifo.sv
rtl/input_unit.sv
rtl/output_allocator.sv
rtl/switch_traversal.sv
rtl/vc_router.sv
tb/tb_vc_router.sv

//--- rtl/flit_pkg.sv
/*
 * Flit format on every router link. Each flit is a single-flit packet
 * made of a header and a payload; the header carries the look-ahead
 * direction to be taken at the next router.
 */
package flit_pkg;

  // data bits per flit
  localparam int payload_width = 16;

  // virtual channel index
  typedef logic [0:0] vc_id_t;

  // ==================================================
  // flit layout
  // ==================================================

  typedef struct packed {
    noc_cfg_pkg::coord_t dst_x;
    noc_cfg_pkg::coord_t dst_y;
    vc_id_t              vc_id;
    noc_cfg_pkg::dir_e   lookahead;
    // spare bits, sent as zero
    logic [1:0]          rsvd;
  } hdr_t;

  typedef logic [payload_width-1:0] payload_t;

  // header in the upper bits, payload below
  typedef struct packed {
    hdr_t     hdr;
    payload_t payload;
  } flit_t;

endpackage

//--- rtl/input_unit.sv
/*
 * One router input. Buffers flits per VC, picks one head VC with a
 * round-robin pointer and requests the output it names. Also computes
 * the look-ahead direction for the router behind that output.
 */
module input_unit #(
  parameter int NumVc   = 2,
  parameter int VcDepth = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  noc_cfg_pkg::coord_t            my_x_i,
  input  noc_cfg_pkg::coord_t            my_y_i,
  input  logic                           data_v_i,
  input  flit_pkg::flit_t                data_i,
  output logic                           credit_v_o,
  output flit_pkg::vc_id_t               credit_id_o,
  output noc_cfg_pkg::port_oh_t          req_dir_oh_o,
  output noc_cfg_pkg::dir_e              req_lookahead_o,
  output flit_pkg::vc_id_t               req_vc_o,
  output noc_cfg_pkg::coord_t [1:0]      req_dst_o,
  input  logic                           grant_i,
  output flit_pkg::payload_t [NumVc-1:0] head_payload_o,
  input  logic                           st_read_i,
  input  flit_pkg::vc_id_t               st_vc_i
);

  logic           [NumVc-1:0] push;
  logic           [NumVc-1:0] hdr_pop;
  logic           [NumVc-1:0] pld_pop;
  logic           [NumVc-1:0] hdr_v;
  flit_pkg::hdr_t [NumVc-1:0] hdr_head;

  flit_pkg::vc_id_t    rr_ptr;
  flit_pkg::vc_id_t    sel_vc;
  logic                sel_v;
  flit_pkg::hdr_t      sel_hdr;
  noc_cfg_pkg::coord_t nb_x;
  noc_cfg_pkg::coord_t nb_y;

  // ==================================================
  // VC buffers
  // ==================================================

  // header half leaves in SA, payload half one cycle later in ST
  for (genvar v = 0; v < NumVc; v++) begin : gen_vc
    assign push[v]    = data_v_i && (data_i.hdr.vc_id == flit_pkg::vc_id_t'(v));
    assign hdr_pop[v] = grant_i && (sel_vc == flit_pkg::vc_id_t'(v));
    assign pld_pop[v] = st_read_i && (st_vc_i == flit_pkg::vc_id_t'(v));

    vc_fifo #(
      .elem_t  (flit_pkg::hdr_t),
      .VcDepth (VcDepth)
    ) i_hdr_fifo (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .push_i   (push[v]),
      .data_i   (data_i.hdr),
      .pop_i    (hdr_pop[v]),
      .head_v_o (hdr_v[v]),
      .head_o   (hdr_head[v])
    );

    vc_fifo #(
      .elem_t  (flit_pkg::payload_t),
      .VcDepth (VcDepth)
    ) i_pld_fifo (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .push_i   (push[v]),
      .data_i   (data_i.payload),
      .pop_i    (pld_pop[v]),
      .head_v_o (),
      .head_o   (head_payload_o[v])
    );
  end

  // ==================================================
  // local switch arbitration
  // ==================================================

  // first valid head at or after the pointer
  always_comb begin
    int unsigned idx;
    sel_v  = 1'b0;
    sel_vc = rr_ptr;
    for (int i = 0; i < NumVc; i++) begin
      idx = (int'(rr_ptr) + i) % NumVc;
      if (!sel_v && hdr_v[idx]) begin
        sel_v  = 1'b1;
        sel_vc = flit_pkg::vc_id_t'(idx);
      end
    end
  end

  // pointer moves past the winner only once the output took it
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_ptr <= '0;
    end else if (grant_i) begin
      rr_ptr <= flit_pkg::vc_id_t'((int'(sel_vc) + 1) % NumVc);
    end
  end

  assign sel_hdr      = hdr_head[sel_vc];
  assign req_vc_o     = sel_vc;
  assign req_dst_o[0] = sel_hdr.dst_x;
  assign req_dst_o[1] = sel_hdr.dst_y;
  assign req_dir_oh_o = sel_v ? (noc_cfg_pkg::port_oh_t'(1) << sel_hdr.lookahead) : '0;

  // ==================================================
  // look-ahead routing
  // ==================================================

  // XY decision taken at the neighbor behind the requested output
  always_comb begin
    nb_x = my_x_i;
    nb_y = my_y_i;
    case (sel_hdr.lookahead)
      noc_cfg_pkg::dir_north: nb_y = my_y_i + 4'd1;
      noc_cfg_pkg::dir_east:  nb_x = my_x_i + 4'd1;
      noc_cfg_pkg::dir_south: nb_y = my_y_i - 4'd1;
      noc_cfg_pkg::dir_west:  nb_x = my_x_i - 4'd1;
      default: ;
    endcase
    if (sel_hdr.dst_x > nb_x) begin
      req_lookahead_o = noc_cfg_pkg::dir_east;
    end else if (sel_hdr.dst_x < nb_x) begin
      req_lookahead_o = noc_cfg_pkg::dir_west;
    end else if (sel_hdr.dst_y > nb_y) begin
      req_lookahead_o = noc_cfg_pkg::dir_north;
    end else if (sel_hdr.dst_y < nb_y) begin
      req_lookahead_o = noc_cfg_pkg::dir_south;
    end else begin
      req_lookahead_o = noc_cfg_pkg::dir_local;
    end
  end

  // a slot frees upstream when the payload leaves in ST
  assign credit_v_o  = st_read_i;
  assign credit_id_o = st_vc_i;

endmodule

//--- rtl/noc_cfg_pkg.sv
/*
 * Mesh-wide configuration of the router: port count, direction codes
 * and coordinate widths. Other files refer to it by scoped names.
 */
package noc_cfg_pkg;

  // ==================================================
  // router geometry
  // ==================================================

  // north, east, south, west and the local core
  localparam int num_ports = 5;

  // port index equals the direction code
  // north is y plus one, east is x plus one
  typedef enum logic [2:0] {
    dir_north = 3'd0,
    dir_east  = 3'd1,
    dir_south = 3'd2,
    dir_west  = 3'd3,
    dir_local = 3'd4
  } dir_e;

  // ==================================================
  // widths
  // ==================================================

  // one mesh coordinate, enough for a 16 x 16 mesh
  typedef logic [3:0] coord_t;

  // one-hot over the router ports, bit n is direction n
  typedef logic [num_ports-1:0] port_oh_t;

endpackage

//--- rtl/output_allocator.sv
/*
 * Switch allocation for one output port. Picks one requesting input
 * round-robin, assigns the lowest downstream VC that still has credit
 * and keeps the credit counters of that link.
 */
module output_allocator #(
  parameter int NumVc   = 2,
  parameter int VcDepth = 2
) (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  logic [noc_cfg_pkg::num_ports-1:0]             req_v_i,
  input  noc_cfg_pkg::dir_e [noc_cfg_pkg::num_ports-1:0] req_lookahead_i,
  input  logic                                          credit_v_i,
  input  flit_pkg::vc_id_t                              credit_id_i,
  output logic                                          alloc_v_o,
  output noc_cfg_pkg::port_oh_t                         alloc_in_oh_o,
  output flit_pkg::vc_id_t                              alloc_vc_o,
  output noc_cfg_pkg::dir_e                             alloc_lookahead_o
);

  localparam int NumIn = noc_cfg_pkg::num_ports;
  localparam int IdxW  = $clog2(NumIn);
  localparam int CntW  = $clog2(VcDepth + 1);

  logic [CntW-1:0] credit_cnt [NumVc];
  logic [IdxW-1:0] rr_ptr;
  logic [IdxW-1:0] win_idx;
  logic            win_v;
  logic            vc_v;

  // ==================================================
  // global switch arbitration
  // ==================================================

  always_comb begin
    int unsigned idx;
    win_v   = 1'b0;
    win_idx = rr_ptr;
    for (int i = 0; i < NumIn; i++) begin
      idx = (int'(rr_ptr) + i) % NumIn;
      if (!win_v && req_v_i[idx]) begin
        win_v   = 1'b1;
        win_idx = IdxW'(idx);
      end
    end
  end

  // ==================================================
  // VC selection
  // ==================================================

  // descending scan so the lowest VC with credit wins
  always_comb begin
    vc_v       = 1'b0;
    alloc_vc_o = '0;
    for (int v = NumVc - 1; v >= 0; v--) begin
      if (credit_cnt[v] != '0) begin
        vc_v       = 1'b1;
        alloc_vc_o = flit_pkg::vc_id_t'(v);
      end
    end
  end

  // no credit on any VC means no grant at all
  assign alloc_v_o         = win_v && vc_v;
  assign alloc_in_oh_o     = alloc_v_o ? (noc_cfg_pkg::port_oh_t'(1) << win_idx) : '0;
  assign alloc_lookahead_o = req_lookahead_i[win_idx];

  // ==================================================
  // arbiter pointer and credit counters
  // ==================================================

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_ptr <= '0;
      for (int v = 0; v < NumVc; v++) begin
        credit_cnt[v] <= CntW'(VcDepth);
      end
    end else begin
      if (alloc_v_o) begin
        rr_ptr <= (win_idx == IdxW'(NumIn - 1)) ? '0 : win_idx + 1'b1;
      end
      // a returned credit and a consumed one may hit the same VC
      for (int v = 0; v < NumVc; v++) begin
        credit_cnt[v] <= credit_cnt[v]
                       + CntW'(credit_v_i && (credit_id_i == flit_pkg::vc_id_t'(v)))
                       - CntW'(alloc_v_o && (alloc_vc_o == flit_pkg::vc_id_t'(v)));
      end
    end
  end

  // downstream returns no more credits than it was given
  for (genvar v = 0; v < NumVc; v++) begin : gen_cnt_chk
    a_cnt_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      credit_cnt[v] <= CntW'(VcDepth));
  end

endmodule

//--- rtl/switch_traversal.sv
/*
 * SA-to-ST pipeline register and the crossbar. Reads the winning
 * payloads out of the input buffers and builds the outgoing flits.
 */
module switch_traversal #(
  parameter int NumVc = 2
) (
  input  logic                                                       clk_i,
  input  logic                                                       rst_n_i,
  input  logic [noc_cfg_pkg::num_ports-1:0]                          alloc_v_i,
  input  noc_cfg_pkg::port_oh_t [noc_cfg_pkg::num_ports-1:0]         alloc_in_oh_i,
  input  flit_pkg::vc_id_t [noc_cfg_pkg::num_ports-1:0]              alloc_vc_i,
  input  noc_cfg_pkg::dir_e [noc_cfg_pkg::num_ports-1:0]             alloc_lookahead_i,
  input  noc_cfg_pkg::coord_t [noc_cfg_pkg::num_ports-1:0][1:0]      hdr_dst_i,
  input  flit_pkg::payload_t [noc_cfg_pkg::num_ports-1:0][NumVc-1:0] head_payload_i,
  input  flit_pkg::vc_id_t [noc_cfg_pkg::num_ports-1:0]              in_vc_i,
  output logic [noc_cfg_pkg::num_ports-1:0]                          st_read_o,
  output flit_pkg::vc_id_t [noc_cfg_pkg::num_ports-1:0]              st_vc_o,
  output logic [noc_cfg_pkg::num_ports-1:0]                          data_v_o,
  output flit_pkg::flit_t [noc_cfg_pkg::num_ports-1:0]               data_o
);

  localparam int P = noc_cfg_pkg::num_ports;

  logic                       [P-1:0]      alloc_v_q;
  noc_cfg_pkg::port_oh_t      [P-1:0]      in_oh_q;
  flit_pkg::vc_id_t           [P-1:0]      out_vc_q;
  noc_cfg_pkg::dir_e          [P-1:0]      lookahead_q;
  noc_cfg_pkg::coord_t        [P-1:0][1:0] dst_q;
  flit_pkg::vc_id_t           [P-1:0]      in_vc_q;

  // ==================================================
  // SA to ST register
  // ==================================================

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      alloc_v_q <= '0;
    end else begin
      alloc_v_q <= alloc_v_i;
    end
  end

  // allocation details carried into the ST cycle
  always_ff @(posedge clk_i) begin
    in_oh_q     <= alloc_in_oh_i;
    out_vc_q    <= alloc_vc_i;
    lookahead_q <= alloc_lookahead_i;
    dst_q       <= hdr_dst_i;
    in_vc_q     <= in_vc_i;
  end

  // ==================================================
  // crossbar
  // ==================================================

  always_comb begin
    st_read_o = '0;
    for (int o = 0; o < P; o++) begin
      for (int i = 0; i < P; i++) begin
        if (alloc_v_q[o] && in_oh_q[o][i]) begin
          st_read_o[i] = 1'b1;
        end
      end
    end
  end

  assign st_vc_o  = in_vc_q;
  assign data_v_o = alloc_v_q;

  // destination follows the flit, VC and look-ahead come from SA
  always_comb begin
    data_o = '0;
    for (int o = 0; o < P; o++) begin
      for (int i = 0; i < P; i++) begin
        if (in_oh_q[o][i]) begin
          data_o[o].hdr.dst_x = dst_q[i][0];
          data_o[o].hdr.dst_y = dst_q[i][1];
          data_o[o].payload   = head_payload_i[i][in_vc_q[i]];
        end
      end
      data_o[o].hdr.vc_id     = out_vc_q[o];
      data_o[o].hdr.lookahead = lookahead_q[o];
    end
  end

  // each input sends at most one flit per cycle, whatever the allocators decide
  for (genvar i = 0; i < P; i++) begin : gen_excl
    logic [P-1:0] sel_col;
    for (genvar o = 0; o < P; o++) begin : gen_col
      assign sel_col[o] = alloc_v_i[o] && alloc_in_oh_i[o][i];
    end
    a_one_output: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(sel_col));
  end

endmodule

//--- rtl/vc_fifo.sv
/*
 * Buffer of one virtual channel. The same module holds either the
 * header or the payload half of a flit, chosen by elem_t.
 */
module vc_fifo #(
  parameter type elem_t  = logic,
  parameter int  VcDepth = 2
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  push_i,
  input  elem_t data_i,
  input  logic  pop_i,
  output logic  head_v_o,
  output elem_t head_o
);

  localparam int PtrW = (VcDepth > 1) ? $clog2(VcDepth) : 1;
  localparam int CntW = $clog2(VcDepth + 1);

  elem_t           mem [VcDepth];
  logic [PtrW-1:0] rd_ptr;
  logic [PtrW-1:0] wr_ptr;
  logic [CntW-1:0] count;

  // circular pointers with a fill count
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= (wr_ptr == PtrW'(VcDepth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= (rd_ptr == PtrW'(VcDepth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CntW'(push_i) - CntW'(pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr] <= data_i;
    end
  end

  assign head_v_o = (count != '0);
  assign head_o   = mem[rd_ptr];

  // the upstream credit count must keep the buffer from overflowing
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> count != CntW'(VcDepth));

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> count != '0);

endmodule

//--- rtl/vc_router.sv
/*
 * Five-port virtual channel router for a 2D mesh. Switch allocation and
 * look-ahead routing share the first cycle, switch traversal the second.
 * my_x_i and my_y_i give the router's place in the mesh.
 */
module vc_router #(
  parameter int NumVc   = 2,
  parameter int VcDepth = 2
) (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  input  noc_cfg_pkg::coord_t                            my_x_i,
  input  noc_cfg_pkg::coord_t                            my_y_i,
  input  logic [noc_cfg_pkg::num_ports-1:0]              data_v_i,
  input  flit_pkg::flit_t [noc_cfg_pkg::num_ports-1:0]   data_i,
  output logic [noc_cfg_pkg::num_ports-1:0]              credit_v_o,
  output flit_pkg::vc_id_t [noc_cfg_pkg::num_ports-1:0]  credit_id_o,
  output logic [noc_cfg_pkg::num_ports-1:0]              data_v_o,
  output flit_pkg::flit_t [noc_cfg_pkg::num_ports-1:0]   data_o,
  input  logic [noc_cfg_pkg::num_ports-1:0]              credit_v_i,
  input  flit_pkg::vc_id_t [noc_cfg_pkg::num_ports-1:0]  credit_id_i
);

  localparam int P = noc_cfg_pkg::num_ports;

  // input space
  noc_cfg_pkg::port_oh_t [P-1:0]            req_dir_oh;
  noc_cfg_pkg::dir_e     [P-1:0]            req_lookahead;
  flit_pkg::vc_id_t      [P-1:0]            req_vc;
  noc_cfg_pkg::coord_t   [P-1:0][1:0]       req_dst;
  logic                  [P-1:0]            grant;
  flit_pkg::payload_t    [P-1:0][NumVc-1:0] head_payload;
  logic                  [P-1:0]            st_read;
  flit_pkg::vc_id_t      [P-1:0]            st_vc;

  // output space
  logic                  [P-1:0][P-1:0]     req_v_per_out;
  logic                  [P-1:0]            alloc_v;
  noc_cfg_pkg::port_oh_t [P-1:0]            alloc_in_oh;
  flit_pkg::vc_id_t      [P-1:0]            alloc_vc;
  noc_cfg_pkg::dir_e     [P-1:0]            alloc_lookahead;

  for (genvar i = 0; i < P; i++) begin : gen_in
    input_unit #(
      .NumVc   (NumVc),
      .VcDepth (VcDepth)
    ) i_input_unit (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .my_x_i          (my_x_i),
      .my_y_i          (my_y_i),
      .data_v_i        (data_v_i[i]),
      .data_i          (data_i[i]),
      .credit_v_o      (credit_v_o[i]),
      .credit_id_o     (credit_id_o[i]),
      .req_dir_oh_o    (req_dir_oh[i]),
      .req_lookahead_o (req_lookahead[i]),
      .req_vc_o        (req_vc[i]),
      .req_dst_o       (req_dst[i]),
      .grant_i         (grant[i]),
      .head_payload_o  (head_payload[i]),
      .st_read_i       (st_read[i]),
      .st_vc_i         (st_vc[i])
    );
  end

  // ==================================================
  // input space to output space
  // ==================================================

  always_comb begin
    grant = '0;
    for (int o = 0; o < P; o++) begin
      for (int i = 0; i < P; i++) begin
        req_v_per_out[o][i] = req_dir_oh[i][o];
        if (alloc_v[o] && alloc_in_oh[o][i]) begin
          grant[i] = 1'b1;
        end
      end
    end
  end

  for (genvar o = 0; o < P; o++) begin : gen_out
    output_allocator #(
      .NumVc   (NumVc),
      .VcDepth (VcDepth)
    ) i_output_allocator (
      .clk_i             (clk_i),
      .rst_n_i           (rst_n_i),
      .req_v_i           (req_v_per_out[o]),
      .req_lookahead_i   (req_lookahead),
      .credit_v_i        (credit_v_i[o]),
      .credit_id_i       (credit_id_i[o]),
      .alloc_v_o         (alloc_v[o]),
      .alloc_in_oh_o     (alloc_in_oh[o]),
      .alloc_vc_o        (alloc_vc[o]),
      .alloc_lookahead_o (alloc_lookahead[o])
    );
  end

  switch_traversal #(
    .NumVc (NumVc)
  ) i_switch_traversal (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .alloc_v_i         (alloc_v),
    .alloc_in_oh_i     (alloc_in_oh),
    .alloc_vc_i        (alloc_vc),
    .alloc_lookahead_i (alloc_lookahead),
    .hdr_dst_i         (req_dst),
    .head_payload_i    (head_payload),
    .in_vc_i           (req_vc),
    .st_read_o         (st_read),
    .st_vc_o           (st_vc),
    .data_v_o          (data_v_o),
    .data_o            (data_o)
  );

endmodule

//--- tb/router_checks.svh
/*
 * Compare tasks and the stop-on-error helper of the router testbench.
 * Included inside the testbench module, one compare task per result type.
 */
`ifndef ROUTER_CHECKS_SVH
`define ROUTER_CHECKS_SVH

  // prints the reason, then the fail line, then stops the run
  task automatic report_failure(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_flit(input string name, input flit_pkg::flit_t got,
                            input flit_pkg::flit_t exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED at %0t ns: %s got %h expected %h",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_vc(input string name, input flit_pkg::vc_id_t got,
                          input flit_pkg::vc_id_t exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED at %0t ns: %s got %0d expected %0d",
                               $time, name, got, exp));
    end
  endtask

  task automatic check_dir(input string name, input noc_cfg_pkg::dir_e got,
                           input noc_cfg_pkg::dir_e exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED at %0t ns: %s got %s expected %s",
                               $time, name, got.name(), exp.name()));
    end
  endtask

`endif

//--- tb/tb_vc_router.sv
/*
 * Directed testbench of the virtual channel router placed at (2,2).
 * Drives flits on the inbound links, models the downstream credits and
 * checks every delivered flit against an XY-routing scoreboard.
 */
module tb_vc_router;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumVc      = 2;
  localparam int VcDepth    = 2;
  localparam int P          = noc_cfg_pkg::num_ports;
  localparam int wait_limit = 200;
  localparam int num_random = 80;

  localparam noc_cfg_pkg::coord_t router_x = 4'd2;
  localparam noc_cfg_pkg::coord_t router_y = 4'd2;

  logic                                 clk = 1'b0;
  logic                                 rst_n;
  logic             [P-1:0]             data_v_in;
  flit_pkg::flit_t  [P-1:0]             data_in;
  logic             [P-1:0]             credit_v_out;
  flit_pkg::vc_id_t [P-1:0]             credit_id_out;
  logic             [P-1:0]             data_v_out;
  flit_pkg::flit_t  [P-1:0]             data_out;
  logic             [P-1:0]             credit_v_in;
  flit_pkg::vc_id_t [P-1:0]             credit_id_in;

  int err_cnt = 0;
  int cycle_cnt = 0;
  int pld_seq = 0;

  // credits sent and returned per port and VC
  int in_sent  [P][NumVc];
  int in_ret   [P][NumVc];
  int out_sent [P][NumVc];
  int out_ret  [P][NumVc];

  // scoreboard keyed by the unique payload
  flit_pkg::flit_t  exp_flit  [flit_pkg::payload_t];
  int               exp_port  [flit_pkg::payload_t];
  flit_pkg::vc_id_t arr_vc    [flit_pkg::payload_t];
  int               arr_cycle [flit_pkg::payload_t];
  int               cred_cycle [P];
  flit_pkg::vc_id_t cred_id    [P];

  // downstream model that returns each credit right after its flit
  bit                         auto_credit = 1'b1;
  logic             [P-1:0]   pend_v = '0;
  flit_pkg::vc_id_t [P-1:0]   pend_id = '0;

  `include "router_checks.svh"

  vc_router #(
    .NumVc   (NumVc),
    .VcDepth (VcDepth)
  ) UUT (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .my_x_i      (router_x),
    .my_y_i      (router_y),
    .data_v_i    (data_v_in),
    .data_i      (data_in),
    .credit_v_o  (credit_v_out),
    .credit_id_o (credit_id_out),
    .data_v_o    (data_v_out),
    .data_o      (data_out),
    .credit_v_i  (credit_v_in),
    .credit_id_i (credit_id_in)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  always @(posedge clk) begin
    if (auto_credit) begin
      credit_v_in  <= pend_v;
      credit_id_in <= pend_id;
    end
  end

  // ==================================================
  // reference routing
  // ==================================================

  function automatic noc_cfg_pkg::dir_e xy_route(input noc_cfg_pkg::coord_t cx,
      input noc_cfg_pkg::coord_t cy, input noc_cfg_pkg::coord_t dx,
      input noc_cfg_pkg::coord_t dy);
    if (dx != cx) begin
      return (dx > cx) ? noc_cfg_pkg::dir_east : noc_cfg_pkg::dir_west;
    end
    if (dy != cy) begin
      return (dy > cy) ? noc_cfg_pkg::dir_north : noc_cfg_pkg::dir_south;
    end
    return noc_cfg_pkg::dir_local;
  endfunction

  function automatic noc_cfg_pkg::coord_t next_x(input noc_cfg_pkg::dir_e d);
    if (d == noc_cfg_pkg::dir_east) return router_x + 4'd1;
    if (d == noc_cfg_pkg::dir_west) return router_x - 4'd1;
    return router_x;
  endfunction

  function automatic noc_cfg_pkg::coord_t next_y(input noc_cfg_pkg::dir_e d);
    if (d == noc_cfg_pkg::dir_north) return router_y + 4'd1;
    if (d == noc_cfg_pkg::dir_south) return router_y - 4'd1;
    return router_y;
  endfunction

  function automatic flit_pkg::payload_t next_payload();
    pld_seq++;
    return {4'($urandom), 12'(pld_seq)};
  endfunction

  function automatic bit has_credit(input int port, input int vc);
    return (in_sent[port][vc] - in_ret[port][vc]) < VcDepth;
  endfunction

  // ==================================================
  // monitor sampling DUT outputs at the falling edge
  // ==================================================

  task automatic check_arrival(input int o, input flit_pkg::flit_t f);
    flit_pkg::flit_t  exp;
    flit_pkg::payload_t p;
    p = f.payload;
    if (!exp_flit.exists(p)) begin
      report_failure($sformatf("output %0d delivered payload %h that was not sent or came twice",
                               o, p));
    end
    if (exp_port[p] != o) begin
      report_failure($sformatf("payload %h left on output %0d instead of output %0d",
                               p, o, exp_port[p]));
    end
    exp = exp_flit[p];
    // any VC with credit may carry it
    exp.hdr.vc_id = f.hdr.vc_id;
    check_dir("data_o.hdr.lookahead", f.hdr.lookahead, exp.hdr.lookahead);
    check_flit("data_o", f, exp);
    out_sent[o][f.hdr.vc_id]++;
    if (out_sent[o][f.hdr.vc_id] - out_ret[o][f.hdr.vc_id] > VcDepth) begin
      report_failure($sformatf("output %0d VC %0d holds more flits than it has credits",
                               o, f.hdr.vc_id));
    end
    arr_vc[p]    = f.hdr.vc_id;
    arr_cycle[p] = cycle_cnt;
    exp_flit.delete(p);
    exp_port.delete(p);
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      for (int o = 0; o < P; o++) begin
        if (credit_v_in[o]) out_ret[o][credit_id_in[o]]++;
      end
      for (int i = 0; i < P; i++) begin
        if (credit_v_out[i]) begin
          in_ret[i][credit_id_out[i]]++;
          cred_cycle[i] = cycle_cnt;
          cred_id[i]    = credit_id_out[i];
        end
      end
      for (int o = 0; o < P; o++) begin
        if (data_v_out[o]) check_arrival(o, data_out[o]);
        pend_id[o] = data_out[o].hdr.vc_id;
      end
      pend_v = data_v_out;
    end
  end

  // ==================================================
  // drivers and waits
  // ==================================================

  // sets up one flit for the coming edge and records what must come out
  task automatic stage_flit(input int port, input int vc, input noc_cfg_pkg::coord_t dx,
                            input noc_cfg_pkg::coord_t dy, input flit_pkg::payload_t pld);
    flit_pkg::flit_t   f;
    flit_pkg::flit_t   e;
    noc_cfg_pkg::dir_e here;
    here            = xy_route(router_x, router_y, dx, dy);
    f               = '0;
    f.hdr.dst_x     = dx;
    f.hdr.dst_y     = dy;
    f.hdr.vc_id     = flit_pkg::vc_id_t'(vc);
    f.hdr.lookahead = here;
    f.payload       = pld;
    e               = f;
    e.hdr.lookahead = xy_route(next_x(here), next_y(here), dx, dy);
    exp_flit[pld]   = e;
    exp_port[pld]   = int'(here);
    in_sent[port][vc]++;
    data_in[port]   <= f;
    data_v_in[port] <= 1'b1;
  endtask

  task automatic wait_input_credit(input int port, input int vc);
    int waited;
    waited = 0;
    @(posedge clk);
    while (!has_credit(port, vc)) begin
      if (waited >= wait_limit) begin
        report_failure($sformatf("no credit came back for input %0d VC %0d", port, vc));
      end
      waited++;
      @(posedge clk);
    end
  endtask

  task automatic send_flit(input int port, input int vc, input noc_cfg_pkg::coord_t dx,
                           input noc_cfg_pkg::coord_t dy, input flit_pkg::payload_t pld);
    wait_input_credit(port, vc);
    stage_flit(port, vc, dx, dy, pld);
    @(posedge clk);
    data_v_in[port] <= 1'b0;
  endtask

  task automatic wait_arrival(input flit_pkg::payload_t pld);
    int waited;
    waited = 0;
    while (exp_flit.exists(pld)) begin
      if (waited >= wait_limit) begin
        report_failure($sformatf("payload %h never left the router", pld));
      end
      waited++;
      @(posedge clk);
    end
  endtask

  // all flits delivered and every credit on both sides returned
  task automatic wait_drain();
    int  waited;
    bit  busy;
    waited = 0;
    busy   = 1'b1;
    while (busy) begin
      busy = (exp_flit.num() != 0);
      for (int i = 0; i < P; i++) begin
        for (int v = 0; v < NumVc; v++) begin
          if (in_sent[i][v] != in_ret[i][v] || out_sent[i][v] != out_ret[i][v]) busy = 1'b1;
        end
      end
      if (busy) begin
        if (waited >= 5 * wait_limit) begin
          report_failure("router did not drain its flits and credits in time");
        end
        waited++;
        @(posedge clk);
      end
    end
  endtask

  task automatic return_credit(input int o, input int vc);
    @(posedge clk);
    credit_v_in[o]  <= 1'b1;
    credit_id_in[o] <= flit_pkg::vc_id_t'(vc);
    @(posedge clk);
    credit_v_in[o]  <= 1'b0;
  endtask

  // ==================================================
  // directed tests
  // ==================================================

  task automatic test_reset_and_east();
    flit_pkg::payload_t p;
    repeat (5) begin
      @(negedge clk);
      if (data_v_out !== '0 || credit_v_out !== '0) begin
        report_failure("data_v_o or credit_v_o is high after reset without traffic");
      end
    end
    p = next_payload();
    send_flit(int'(noc_cfg_pkg::dir_west), 1, 4'd4, 4'd2, p);
    wait_arrival(p);
    check_vc("data_o.hdr.vc_id", arr_vc[p], 1'b0);
    if (cred_cycle[noc_cfg_pkg::dir_west] != arr_cycle[p]) begin
      report_failure("credit_v_o on West did not pulse together with the flit");
    end
    check_vc("credit_id_o", cred_id[noc_cfg_pkg::dir_west], 1'b1);
    wait_drain();
  endtask

  task automatic test_local_delivery();
    flit_pkg::payload_t p;
    p = next_payload();
    send_flit(int'(noc_cfg_pkg::dir_north), 0, router_x, router_y, p);
    wait_arrival(p);
    wait_drain();
  endtask

  task automatic test_back_pressure();
    flit_pkg::payload_t p [5];
    flit_pkg::vc_id_t   exp_vc [4];
    exp_vc = '{1'b0, 1'b0, 1'b1, 1'b1};
    @(negedge clk);
    auto_credit = 1'b0;
    for (int k = 0; k < 5; k++) begin
      p[k] = next_payload();
      send_flit(int'(noc_cfg_pkg::dir_west), 0, 4'd4, 4'd2, p[k]);
    end
    for (int k = 0; k < 4; k++) begin
      wait_arrival(p[k]);
      check_vc("data_o.hdr.vc_id", arr_vc[p[k]], exp_vc[k]);
    end
    // East has no credit left so the fifth flit must stay parked
    repeat (30) begin
      @(posedge clk);
      if (!exp_flit.exists(p[4])) begin
        report_failure("a flit left East although no credit was returned");
      end
    end
    return_credit(int'(noc_cfg_pkg::dir_east), 1);
    wait_arrival(p[4]);
    check_vc("data_o.hdr.vc_id", arr_vc[p[4]], 1'b1);
    return_credit(int'(noc_cfg_pkg::dir_east), 0);
    return_credit(int'(noc_cfg_pkg::dir_east), 0);
    return_credit(int'(noc_cfg_pkg::dir_east), 1);
    return_credit(int'(noc_cfg_pkg::dir_east), 1);
    @(negedge clk);
    auto_credit = 1'b1;
    wait_drain();
  endtask

  task automatic test_same_cycle_pair();
    flit_pkg::payload_t pa;
    flit_pkg::payload_t pb;
    pa = next_payload();
    pb = next_payload();
    @(posedge clk);
    stage_flit(int'(noc_cfg_pkg::dir_south), 0, 4'd2, 4'd4, pa);
    stage_flit(int'(noc_cfg_pkg::dir_local), 0, 4'd2, 4'd4, pb);
    @(posedge clk);
    data_v_in <= '0;
    wait_arrival(pa);
    wait_arrival(pb);
    wait_drain();
  endtask

  task automatic test_random_traffic();
    int           sent;
    int           cycles;
    int           vc;
    logic [P-1:0] valid;
    sent   = 0;
    cycles = 0;
    while (sent < num_random) begin
      if (cycles >= 10 * wait_limit) begin
        report_failure("random traffic could not inject all flits in time");
      end
      cycles++;
      @(posedge clk);
      valid = '0;
      for (int i = 0; i < P; i++) begin
        vc = $urandom_range(NumVc - 1, 0);
        if (sent < num_random && $urandom_range(1, 0) == 1 && has_credit(i, vc)) begin
          stage_flit(i, vc, 4'($urandom_range(4, 0)), 4'($urandom_range(4, 0)),
                     next_payload());
          valid[i] = 1'b1;
          sent++;
        end
      end
      data_v_in <= valid;
    end
    @(posedge clk);
    data_v_in <= '0;
    wait_drain();
  endtask

  initial begin
    void'($urandom(4447));
    rst_n        = 1'b0;
    data_v_in    = '0;
    data_in      = '0;
    credit_v_in  = '0;
    credit_id_in = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_and_east();
    test_local_delivery();
    test_back_pressure();
    test_same_cycle_pair();
    test_random_traffic();
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
